//--- dv/imuldiv_unit_tb.sv
// testbench for the iterative multiply/divide unit
// table of fixed and random requests, responses matched in order
`timescale 1ns/1ps

module imuldiv_unit_tb;

  import imuldiv_msg_pkg::*;

  localparam int NUM_FIXED      = 20;
  localparam int NUM_RAND       = 40;
  localparam int NUM_VEC        = NUM_FIXED + NUM_RAND;
  // random rows from here on stall the response side
  localparam int STALL_START    = 40;
  // req transfer edge to resp_val, unit otherwise empty
  localparam int LATENCY        = 34;
  localparam int TIMEOUT_CYCLES = NUM_VEC * 50 + 100;

  // one table row
  typedef struct packed {
    muldiv_req_t         req;
    logic [RESULT_W-1:0] exp;
    // resp_rdy low for each set bit, bit 7 kept clear
    logic [7:0]          stall;
    // hold the request back until the unit is empty
    logic                drain;
  } vec_t;

  logic         clk;
  logic         reset;
  muldiv_req_t  req;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp;
  logic         resp_val;
  logic         resp_rdy;

  vec_t tbl [NUM_VEC];
  int   accept_edge [NUM_VEC];
  // nothing outstanding when the request went in
  bit   solo [NUM_VEC];
  // table indices in flight, oldest first
  int   pending [$];
  int   cycle = 0;
  int   seed = 32'h742a_8882;

  imuldiv_unit dut0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // ------------------------------------------------------------------------
  // failure reporting and compare tasks
  // ------------------------------------------------------------------------

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_result(input string name, input logic [RESULT_W-1:0] exp,
                              input logic [RESULT_W-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch at %0t: %s expected 0x%h, actual 0x%h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_fn(input string name, input muldiv_fn_e exp, input muldiv_fn_e act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch at %0t: %s expected %s, actual %s",
                                  $time, name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Mismatch at %0t: %s expected %b, actual %b",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_with_failure($sformatf("Mismatch at %0t: %s expected %0d, actual %0d",
                                  $time, name, exp, act));
    end
  endtask

  // ------------------------------------------------------------------------
  // reference model and vector table
  // ------------------------------------------------------------------------

  // 64-bit arithmetic on sign or zero extended operands
  function automatic logic [RESULT_W-1:0] model_result(input muldiv_req_t r);
    longint              sa;
    longint              sb;
    longint              sq;
    longint              sr;
    logic [RESULT_W-1:0] ua;
    logic [RESULT_W-1:0] ub;
    logic [RESULT_W-1:0] uq;
    logic [RESULT_W-1:0] ur;
    logic [RESULT_W-1:0] res;
    sa = {{OPND_W{r.a[OPND_W-1]}}, r.a};
    sb = {{OPND_W{r.b[OPND_W-1]}}, r.b};
    ua = {{OPND_W{1'b0}}, r.a};
    ub = {{OPND_W{1'b0}}, r.b};
    case (r.fn)
      MUL:  res = sa * sb;
      MULU: res = ua * ub;
      DIV, DIVU: begin
        if (r.b == '0) begin
          // all-ones quotient, dividend as remainder
          res = {r.a, {OPND_W{1'b1}}};
        end else if (r.fn == DIV) begin
          // truncating divide, remainder follows the dividend
          sq  = sa / sb;
          sr  = sa % sb;
          res = {sr[OPND_W-1:0], sq[OPND_W-1:0]};
        end else begin
          uq  = ua / ub;
          ur  = ua % ub;
          res = {ur[OPND_W-1:0], uq[OPND_W-1:0]};
        end
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  function automatic vec_t make_vec(input muldiv_fn_e fn, input logic [OPND_W-1:0] a,
                                    input logic [OPND_W-1:0] b,
                                    input logic [RESULT_W-1:0] exp, input logic drain);
    vec_t v;
    v.req.fn = fn;
    v.req.a  = a;
    v.req.b  = b;
    v.exp    = exp;
    v.stall  = '0;
    v.drain  = drain;
    return v;
  endfunction

  task automatic build_table();
    muldiv_req_t       r;
    logic [OPND_W-1:0] a;
    logic [OPND_W-1:0] b;
    logic [31:0]       sel;
    // products, all sign combinations and the extremes
    tbl[0]  = make_vec(MUL,  32'd3,         32'd7,         64'h0000_0000_0000_0015, 1'b1);
    tbl[1]  = make_vec(MUL,  32'hffff_fffd, 32'd7,         64'hffff_ffff_ffff_ffeb, 1'b0);
    tbl[2]  = make_vec(MUL,  32'hffff_fffd, 32'hffff_fff9, 64'h0000_0000_0000_0015, 1'b0);
    tbl[3]  = make_vec(MULU, 32'hffff_ffff, 32'hffff_ffff, 64'hffff_fffe_0000_0001, 1'b0);
    tbl[4]  = make_vec(MUL,  32'hffff_ffff, 32'hffff_ffff, 64'h0000_0000_0000_0001, 1'b1);
    tbl[5]  = make_vec(MUL,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000, 1'b0);
    tbl[6]  = make_vec(MUL,  32'h8000_0000, 32'h7fff_ffff, 64'hc000_0000_8000_0000, 1'b0);
    tbl[7]  = make_vec(MUL,  32'h7fff_ffff, 32'h7fff_ffff, 64'h3fff_ffff_0000_0001, 1'b0);
    tbl[8]  = make_vec(MULU, 32'h8000_0000, 32'd2,         64'h0000_0001_0000_0000, 1'b0);
    tbl[9]  = make_vec(MULU, 32'd0,         32'h1234_5678, 64'h0000_0000_0000_0000, 1'b1);
    // divides, remainder high and quotient low
    tbl[10] = make_vec(DIV,  32'd7,         32'd2,         64'h0000_0001_0000_0003, 1'b0);
    tbl[11] = make_vec(DIV,  32'hffff_fff9, 32'd2,         64'hffff_ffff_ffff_fffd, 1'b0);
    tbl[12] = make_vec(DIV,  32'd7,         32'hffff_fffe, 64'h0000_0001_ffff_fffd, 1'b0);
    tbl[13] = make_vec(DIV,  32'hffff_fff9, 32'hffff_fffe, 64'hffff_ffff_0000_0003, 1'b0);
    tbl[14] = make_vec(DIVU, 32'hffff_fff9, 32'd2,         64'h0000_0001_7fff_fffc, 1'b1);
    tbl[15] = make_vec(DIV,  32'd12,        32'hffff_fffb, 64'h0000_0002_ffff_fffe, 1'b0);
    // divide by zero and signed overflow
    tbl[16] = make_vec(DIV,  32'd100,       32'd0,         64'h0000_0064_ffff_ffff, 1'b0);
    tbl[17] = make_vec(DIVU, 32'hffff_fff9, 32'd0,         64'hffff_fff9_ffff_ffff, 1'b0);
    tbl[18] = make_vec(DIV,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000, 1'b1);
    tbl[19] = make_vec(DIVU, 32'h8000_0000, 32'hffff_ffff, 64'h8000_0000_0000_0000, 1'b0);
    for (int i = NUM_FIXED; i < NUM_VEC; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      sel = $random(seed);
      // one divisor in four is small, zero among them
      if (sel[3:2] == 2'b00) begin
        b = b & 32'h0000_000f;
      end
      r.fn         = muldiv_fn_e'(sel[1:0]);
      r.a          = a;
      r.b          = b;
      tbl[i].req   = r;
      tbl[i].exp   = model_result(r);
      tbl[i].stall = (i >= STALL_START) ? (sel[15:8] & 8'h7f) : 8'h00;
      tbl[i].drain = (i == NUM_FIXED) || (sel[7:4] == 4'h0);
    end
  endtask

  // ------------------------------------------------------------------------
  // cycle count and timeout
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("timeout after %0d cycles, the unit hung", cycle));
    end
  end

  // ------------------------------------------------------------------------
  // stimulus and response checking, all on the falling edge
  // ------------------------------------------------------------------------

  initial begin : run
    int           issue_idx;
    int           n_done;
    int           idx;
    int           lat;
    bit           req_fire;
    bit           resp_fire;
    bit           held;
    bit           head_seen;
    bit           saw_full;
    logic [2:0]   stall_pos;
    muldiv_resp_t held_resp;
    reset     = 1'b1;
    req       = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    issue_idx = 0;
    n_done    = 0;
    req_fire  = 1'b0;
    resp_fire = 1'b0;
    held      = 1'b0;
    head_seen = 1'b0;
    saw_full  = 1'b0;
    stall_pos = '0;
    held_resp = '0;
    build_table();
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_flag("req_rdy after reset", 1'b1, req_rdy);
    check_flag("resp_val after reset", 1'b0, resp_val);

    while (n_done < NUM_VEC) begin
      @(negedge clk);
      // transfers on the rising edge just passed, response side first
      if (resp_fire) begin
        void'(pending.pop_front());
        n_done++;
        head_seen = 1'b0;
        stall_pos = '0;
      end
      if (req_fire) begin
        pending.push_back(issue_idx);
        accept_edge[issue_idx] = cycle;
        issue_idx++;
      end

      // a stalled response must not move
      if (held) begin
        check_flag("resp_val while stalled", 1'b1, resp_val);
        check_fn("resp.fn while stalled", held_resp.fn, resp.fn);
        check_result("resp.result while stalled", held_resp.result, resp.result);
      end
      if (resp_val && !head_seen) begin
        if (pending.size() == 0) begin
          stop_with_failure("a response arrived with no request outstanding");
        end else begin
          idx = pending[0];
          check_fn("resp.fn", tbl[idx].req.fn, resp.fn);
          check_result("resp.result", tbl[idx].exp, resp.result);
          lat = cycle - accept_edge[idx];
          if (solo[idx]) begin
            check_count("resp_val latency", LATENCY, lat);
          end else if (lat < LATENCY) begin
            stop_with_failure($sformatf("response %0d came back after only %0d cycles",
                                        idx, lat));
          end
          head_seen = 1'b1;
        end
      end
      if (!req_rdy && issue_idx >= STALL_START) begin
        saw_full = 1'b1;
      end

      // next request, held until it transfers
      if (issue_idx < NUM_VEC && !(tbl[issue_idx].drain && pending.size() != 0)) begin
        req     = tbl[issue_idx].req;
        req_val = 1'b1;
      end else begin
        req_val = 1'b0;
      end
      // response ready follows the stall pattern of the oldest request
      if (pending.size() != 0) begin
        stall_pos = stall_pos + 3'd1;
        resp_rdy  = !tbl[pending[0]].stall[stall_pos];
      end else begin
        resp_rdy = 1'b1;
      end

      // what the next rising edge will transfer
      req_fire = req_val && req_rdy;
      if (req_fire) begin
        solo[issue_idx] = (pending.size() == 0);
      end
      resp_fire = resp_val && resp_rdy;
      held      = resp_val && !resp_rdy;
      held_resp = resp;
    end

    if (!saw_full) begin
      stop_with_failure("req_rdy never went low while responses were stalled");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- hdl/imuldiv_decode.sv
// multiply/divide decode stage
// registers the request and turns signed operands into magnitudes
`timescale 1ns/1ps

module imuldiv_decode (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_msg_pkg::muldiv_req_t  req,
  input  logic                          req_val,
  output logic                          req_rdy,
  output imuldiv_iter_pkg::decoded_op_t op,
  output logic                          op_val,
  input  logic                          op_rdy
);

  import imuldiv_msg_pkg::*;
  import imuldiv_iter_pkg::*;

  logic        req_fire;
  logic        is_signed;
  logic        a_neg;
  logic        b_neg;
  decoded_op_t op_next;

  // ------------------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------------------

  // the register takes a new request when empty or when it hands off
  // its current op in the same cycle
  assign req_rdy  = !op_val || op_rdy;
  assign req_fire = req_val && req_rdy;

  // ------------------------------------------------------------------------
  // operand decode
  // ------------------------------------------------------------------------

  always_comb begin
    // only MUL and DIV look at the sign bits
    is_signed = (req.fn == MUL) || (req.fn == DIV);
    a_neg     = is_signed && req.a[OPND_W-1];
    b_neg     = is_signed && req.b[OPND_W-1];

    op_next.fn     = req.fn;
    op_next.is_div = (req.fn == DIV) || (req.fn == DIVU);

    // two's complement magnitude
    // the most negative value maps onto itself as an unsigned number
    op_next.a_mag = a_neg ? (~req.a + 1'b1) : req.a;
    op_next.b_mag = b_neg ? (~req.b + 1'b1) : req.b;

    op_next.a_neg   = a_neg;
    // product and quotient are negative when exactly one operand is
    op_next.res_neg = a_neg ^ b_neg;
    op_next.b_zero  = (req.b == '0);
    op_next.a_orig  = req.a;
  end

  // ------------------------------------------------------------------------
  // request register
  // ------------------------------------------------------------------------

  // valid bit
  always_ff @(posedge clk) begin
    if (reset) begin
      op_val <= 1'b0;
    end else if (req_fire) begin
      op_val <= 1'b1;
    end else if (op_rdy) begin
      op_val <= 1'b0;
    end
  end

  // payload only moves on an accepted request
  always_ff @(posedge clk) begin
    if (req_fire) begin
      op <= op_next;
    end
  end

endmodule

//--- hdl/imuldiv_div_iterative.sv
// iterative restoring divider
// 32 steps over operand magnitudes, remainder high and quotient low
`timescale 1ns/1ps

module imuldiv_div_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_iter_pkg::decoded_op_t op,
  input  logic                          start,
  output logic                          busy,
  output logic                          done_val,
  input  logic                          done_rdy,
  output imuldiv_iter_pkg::raw_result_t raw
);

  import imuldiv_msg_pkg::*;
  import imuldiv_iter_pkg::*;

  exec_state_e       state;
  logic [CNT_W-1:0]  count;
  logic              load;
  logic              step;
  decoded_op_t       op_reg;
  // partial remainder in the upper half, dividend then quotient below
  logic [RESULT_W:0] rq;
  // divisor placed in the upper half
  logic [RESULT_W:0] dvsr;
  logic [RESULT_W:0] rq_shift;
  logic [RESULT_W:0] diff;
  logic [RESULT_W:0] rq_next;

  assign busy     = (state != IDLE);
  assign done_val = (state == DONE);
  assign load     = (state == IDLE) && start;
  assign step     = (state == CALC);

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          if (count == LAST_STEP) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          // wait for the result stage
          if (done_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // one restoring step
  // ------------------------------------------------------------------------

  always_comb begin
    rq_shift = rq << 1;
    diff     = rq_shift - dvsr;
    // msb of the difference set means the trial subtract went negative
    if (diff[RESULT_W]) begin
      // restore, quotient bit stays zero
      rq_next = rq_shift;
    end else begin
      rq_next = {diff[RESULT_W:1], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      op_reg <= op;
      rq     <= {{(OPND_W+1){1'b0}}, op.a_mag};
      dvsr   <= {1'b0, op.b_mag, {OPND_W{1'b0}}};
    end else if (step) begin
      rq <= rq_next;
    end
  end

  // remainder below the spare top bit, quotient in the low word
  assign raw.op = op_reg;
  assign raw.hi = rq[RESULT_W-1:OPND_W];
  assign raw.lo = rq[OPND_W-1:0];

endmodule

//--- hdl/imuldiv_iter_pkg.sv
// iterative execute constants and the structs passed between the stages
// of the multiply/divide unit
package imuldiv_iter_pkg;

  import imuldiv_msg_pkg::*;

  // ------------------------------------------------------------------------
  // iteration control
  // ------------------------------------------------------------------------

  // one operand bit per step
  localparam int ITER_COUNT = 32;
  localparam int CNT_W      = 6;
  // counter value on the final step
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(ITER_COUNT - 1);

  // execute unit control states, shared by the multiplier and the divider
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } exec_state_e;

  // ------------------------------------------------------------------------
  // stage payloads
  // ------------------------------------------------------------------------

  // decoded operation, from decode into execute
  typedef struct packed {
    muldiv_fn_e        fn;
    logic              is_div;
    logic [OPND_W-1:0] a_mag;
    logic [OPND_W-1:0] b_mag;
    // sign of the dividend or multiplicand
    logic              a_neg;
    // quotient or product must be negated
    logic              res_neg;
    logic              b_zero;
    // original dividend for the divide-by-zero remainder
    logic [OPND_W-1:0] a_orig;
  } decoded_op_t;

  // unsigned result of an execute unit, from execute into result
  typedef struct packed {
    decoded_op_t       op;
    logic [OPND_W-1:0] hi;
    logic [OPND_W-1:0] lo;
  } raw_result_t;

endpackage

//--- hdl/imuldiv_msg_pkg.sv
// integer multiply/divide message formats
// request and response structs and the function encoding
package imuldiv_msg_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------

  // operands are one machine word
  localparam int OPND_W   = 32;
  // full product, or remainder and quotient side by side
  localparam int RESULT_W = 64;

  // ------------------------------------------------------------------------
  // function encoding
  // ------------------------------------------------------------------------

  // bit 1 picks divide, bit 0 picks the unsigned form
  typedef enum logic [1:0] {
    MUL  = 2'd0,
    MULU = 2'd1,
    DIV  = 2'd2,
    DIVU = 2'd3
  } muldiv_fn_e;

  // ------------------------------------------------------------------------
  // messages
  // ------------------------------------------------------------------------

  // request, 66 bits
  // a is the multiplicand or dividend
  // b is the multiplier or divisor
  typedef struct packed {
    muldiv_fn_e          fn;
    logic [OPND_W-1:0]   a;
    logic [OPND_W-1:0]   b;
  } muldiv_req_t;

  // response, 66 bits
  // fn is echoed back from the request
  // divide packs the remainder high and the quotient low
  typedef struct packed {
    muldiv_fn_e          fn;
    logic [RESULT_W-1:0] result;
  } muldiv_resp_t;

endpackage

//--- hdl/imuldiv_mul_iterative.sv
// iterative shift-add multiplier
// 32 steps over operand magnitudes, sign fixed later in the result stage
`timescale 1ns/1ps

module imuldiv_mul_iterative (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_iter_pkg::decoded_op_t op,
  input  logic                          start,
  output logic                          busy,
  output logic                          done_val,
  input  logic                          done_rdy,
  output imuldiv_iter_pkg::raw_result_t raw
);

  import imuldiv_msg_pkg::*;
  import imuldiv_iter_pkg::*;

  exec_state_e         state;
  logic [CNT_W-1:0]    count;
  logic                load;
  logic                step;
  decoded_op_t         op_reg;
  // running sum of partial products
  logic [RESULT_W-1:0] acc;
  // multiplicand, moves one place left each step
  logic [RESULT_W-1:0] mcand;
  // multiplier, lsb is the bit in use this step
  logic [OPND_W-1:0]   mplier;

  assign busy     = (state != IDLE);
  assign done_val = (state == DONE);
  assign load     = (state == IDLE) && start;
  assign step     = (state == CALC);

  // ------------------------------------------------------------------------
  // control
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // last step lands on the DONE edge
          if (count == LAST_STEP) begin
            state <= DONE;
          end
          count <= count + 1'b1;
        end
        DONE: begin
          // hold the product until the result stage takes it
          if (done_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      op_reg <= op;
      acc    <= '0;
      mcand  <= {{OPND_W{1'b0}}, op.a_mag};
      mplier <= op.b_mag;
    end else if (step) begin
      // add the shifted multiplicand for a set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign raw.op = op_reg;
  assign raw.hi = acc[RESULT_W-1:OPND_W];
  assign raw.lo = acc[OPND_W-1:0];

endmodule

//--- hdl/imuldiv_result.sv
// multiply/divide result stage
// restores signs, applies the divide-by-zero rule, registers the response
`timescale 1ns/1ps

module imuldiv_result (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_iter_pkg::raw_result_t raw,
  input  logic                          raw_val,
  output logic                          raw_rdy,
  output imuldiv_msg_pkg::muldiv_resp_t resp,
  output logic                          resp_val,
  input  logic                          resp_rdy
);

  import imuldiv_msg_pkg::*;

  logic                raw_fire;
  logic [RESULT_W-1:0] prod;
  logic [OPND_W-1:0]   quot;
  logic [OPND_W-1:0]   rem;
  logic [RESULT_W-1:0] result;

  // ------------------------------------------------------------------------
  // handshake
  // ------------------------------------------------------------------------

  // free when empty or drained this cycle
  assign raw_rdy  = !resp_val || resp_rdy;
  assign raw_fire = raw_val && raw_rdy;

  // ------------------------------------------------------------------------
  // sign correction
  // ------------------------------------------------------------------------

  always_comb begin
    // full 64-bit negate for the product
    prod = {raw.hi, raw.lo};
    if (raw.op.res_neg) begin
      prod = ~prod + 1'b1;
    end

    // quotient truncates toward zero
    quot = raw.op.res_neg ? (~raw.lo + 1'b1) : raw.lo;
    // remainder follows the dividend
    rem  = raw.op.a_neg ? (~raw.hi + 1'b1) : raw.hi;

    // divide by zero, for signed and unsigned alike
    if (raw.op.b_zero) begin
      quot = '1;
      rem  = raw.op.a_orig;
    end

    result = raw.op.is_div ? {rem, quot} : prod;
  end

  // ------------------------------------------------------------------------
  // response register
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (raw_fire) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // held steady while resp_val waits on resp_rdy
  always_ff @(posedge clk) begin
    if (raw_fire) begin
      resp.fn     <= raw.op.fn;
      resp.result <= result;
    end
  end

endmodule

//--- hdl/imuldiv_unit.sv
// iterative integer multiply/divide unit
// decode, iterative multiplier and divider, result register
`timescale 1ns/1ps

module imuldiv_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  imuldiv_msg_pkg::muldiv_req_t  req,
  input  logic                          req_val,
  output logic                          req_rdy,
  output imuldiv_msg_pkg::muldiv_resp_t resp,
  output logic                          resp_val,
  input  logic                          resp_rdy
);

  import imuldiv_iter_pkg::*;

  decoded_op_t op;
  logic        op_val;
  logic        op_rdy;
  logic        mul_busy;
  logic        div_busy;
  logic        mul_done_val;
  logic        div_done_val;
  logic        mul_done_rdy;
  logic        div_done_rdy;
  raw_result_t mul_raw;
  raw_result_t div_raw;
  raw_result_t raw;
  logic        raw_val;
  logic        raw_rdy;

  // ------------------------------------------------------------------------
  // decode to execute routing
  // ------------------------------------------------------------------------

  // a divide also waits for a running multiply
  // so the older op is always the one the divider-first pick favours
  assign op_rdy = op.is_div ? (!div_busy && !mul_busy) : !mul_busy;

  // ------------------------------------------------------------------------
  // execute to result, divider first
  // ------------------------------------------------------------------------

  assign raw_val      = div_done_val || mul_done_val;
  assign raw          = div_done_val ? div_raw : mul_raw;
  assign div_done_rdy = raw_rdy;
  assign mul_done_rdy = raw_rdy && !div_done_val;

  imuldiv_decode decode0 (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .op      (op),
    .op_val  (op_val),
    .op_rdy  (op_rdy)
  );

  imuldiv_mul_iterative mul0 (
    .clk      (clk),
    .reset    (reset),
    .op       (op),
    .start    (op_val && !op.is_div && op_rdy),
    .busy     (mul_busy),
    .done_val (mul_done_val),
    .done_rdy (mul_done_rdy),
    .raw      (mul_raw)
  );

  imuldiv_div_iterative div0 (
    .clk      (clk),
    .reset    (reset),
    .op       (op),
    .start    (op_val && op.is_div && op_rdy),
    .busy     (div_busy),
    .done_val (div_done_val),
    .done_rdy (div_done_rdy),
    .raw      (div_raw)
  );

  imuldiv_result result0 (
    .clk      (clk),
    .reset    (reset),
    .raw      (raw),
    .raw_val  (raw_val),
    .raw_rdy  (raw_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

endmodule

//--- imuldiv_unit.f
hdl/imuldiv_msg_pkg.sv
hdl/imuldiv_iter_pkg.sv
hdl/imuldiv_decode.sv
hdl/imuldiv_mul_iterative.sv
hdl/imuldiv_div_iterative.sv
hdl/imuldiv_result.sv
hdl/imuldiv_unit.sv
dv/imuldiv_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the multiply/divide unit testbench with Verilator and run it
# exit status is zero only when the simulation passes

cd "$(dirname "$0")" &&
  verilator --binary --timing \
    --top-module imuldiv_unit_tb \
    -f imuldiv_unit.f \
    -o imuldiv_unit_sim &&
  ./obj_dir/imuldiv_unit_sim ||
  { echo "simulation run did not pass"; exit 1; }
